/* Makefile */
VERILATOR ?= verilator
TOP       ?= cp0_tb
FILELIST  ?= cp0_tlb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
TESTS     ?= bench/cp0_tlb_tests.txt
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard design/*.sv bench/*.sv)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM) $(TESTS)
	./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Done: errors found" $(LOG); then \
	    echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/cp0_tb.sv */
module cp0_tb;
    import cp0_pkg::*;

    localparam string TESTS_FILE = "bench/cp0_tlb_tests.txt";

    // operands of one step, as read from the tests file
    typedef struct packed {
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        logic [31:0] e;
    } step_args_t;

    logic              clk;
    logic              rst;
    cp0_cmd_t          cmd;
    logic [31:0]       mtc0_wdata;
    exc_t              exc;
    logic [31:0]       exc_pc;
    logic              exc_bd;
    logic [31:0]       mem_va;
    logic [VPN2_W-1:0] lookup_vpn2;
    logic [31:0]       mfc0_rdata;
    logic              jump;
    logic [31:0]       jump_pc;
    logic              lookup_found;
    tlb_entry_t        lookup_entry;

    string      step_op [$];
    step_args_t step_args [$];
    int         errors = 0;
    int         checks = 0;
    int         cycles = 0;
    int         cycle_limit = 1000000;

    cp0_top cp0_top_inst (
        .clk          (clk),
        .rst          (rst),
        .cmd          (cmd),
        .mtc0_wdata   (mtc0_wdata),
        .exc          (exc),
        .exc_pc       (exc_pc),
        .exc_bd       (exc_bd),
        .mem_va       (mem_va),
        .lookup_vpn2  (lookup_vpn2),
        .mfc0_rdata   (mfc0_rdata),
        .jump         (jump),
        .jump_pc      (jump_pc),
        .lookup_found (lookup_found),
        .lookup_entry (lookup_entry)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
            $display("checks: %0d, errors: %0d", checks, errors);
            $display("Done: errors found");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("error at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_range(input string name, input logic [31:0] low,
                               input logic [31:0] high, input logic [31:0] actual);
        checks++;
        assert (actual >= low && actual <= high) else begin
            errors++;
            $display("error at %0t: %s expected %h to %h, got %h", $time, name, low, high,
                     actual);
        end
    endtask

    task automatic clear_inputs();
        cmd         = '0;
        mtc0_wdata  = '0;
        exc         = '0;
        exc_pc      = '0;
        exc_bd      = 1'b0;
        mem_va      = '0;
        lookup_vpn2 = '0;
    endtask

    // lines whose first token starts with # are comments
    task automatic load_tests();
        int         fd;
        int         code;
        string      op;
        string      rest;
        step_args_t args;
        fd = $fopen(TESTS_FILE, "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the tests file %s", TESTS_FILE);
            return;
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", op);
            if (code != 1) begin
                break;
            end
            if (op.substr(0, 0) == "#") begin
                code = $fgets(rest, fd);
            end else begin
                code = $fscanf(fd, "%h %h %h %h %h", args.a, args.b, args.c, args.d, args.e);
                if (code != 5) begin
                    errors++;
                    $display("step %s in the tests file has missing operands", op);
                    break;
                end
                step_op.push_back(op);
                step_args.push_back(args);
            end
        end
        $fclose(fd);
        if (step_op.size() == 0) begin
            errors++;
            $display("no test steps were read from %s", TESTS_FILE);
        end
    endtask

    task automatic run_step(input string op, input step_args_t args);
        string reg_name;
        @(negedge clk);
        clear_inputs();
        case (op)
            "mtc0": begin
                cmd.mtc0_en  = 1'b1;
                cmd.reg_addr = args.a[4:0];
                mtc0_wdata   = args.b;
            end
            "mfc0", "range": cmd.reg_addr = args.a[4:0];
            "tlbwi": cmd.tlbwi = 1'b1;
            "tlbwr": cmd.tlbwr = 1'b1;
            "tlbp":  cmd.tlbp = 1'b1;
            "tlbr":  cmd.tlbr = 1'b1;
            "look":  lookup_vpn2 = args.a[VPN2_W-1:0];
            "exc": begin
                exc    = exc_t'(args.a[12:0]);
                exc_pc = args.b;
                exc_bd = args.c[0];
                mem_va = args.d;
            end
            "eret": exc.eret = 1'b1;
            default: begin
                errors++;
                $display("unknown operation %s in the tests file", op);
            end
        endcase
        // let the combinational outputs settle well before the rising edge
        #1;
        reg_name = $sformatf("mfc0_rdata of reg %0d", args.a[4:0]);
        if (op == "exc") begin
            check_value("jump", 32'd1, {31'd0, jump});
            check_value("jump_pc", args.e, jump_pc);
        end else if (op == "eret") begin
            check_value("jump", 32'd1, {31'd0, jump});
            check_value("jump_pc", args.a, jump_pc);
        end else begin
            check_value("jump", 32'd0, {31'd0, jump});
        end
        if (op == "mfc0") begin
            check_value(reg_name, args.b, mfc0_rdata);
        end
        if (op == "range") begin
            check_range(reg_name, args.b, args.c, mfc0_rdata);
        end
        if (op == "look") begin
            check_value("lookup_found", args.b, {31'd0, lookup_found});
            if (args.b[0]) begin
                check_value("lookup_entry.pfn0", args.c, 32'(lookup_entry.pfn0));
                check_value("lookup_entry.pfn1", args.d, 32'(lookup_entry.pfn1));
                check_value("lookup_entry d0 v0 d1 v1", args.e,
                            {28'd0, lookup_entry.d0, lookup_entry.v0,
                             lookup_entry.d1, lookup_entry.v1});
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        clear_inputs();
        load_tests();
        cycle_limit = step_op.size() * 4 + 20;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        foreach (step_op[i]) begin
            run_step(step_op[i], step_args[i]);
        end
        @(negedge clk);
        clear_inputs();
        @(negedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* bench/cp0_tlb_tests.txt */
# op a b c d e, all operands hex; mtc0 reg data / mfc0 reg expect / range reg low high
# look vpn2 found pfn0 pfn1 {d0,v0,d1,v1} / exc flags pc bd va jump_pc / eret jump_pc
# masked writes, unlisted registers read zero
mtc0  0c ffffffff 0 0 0
mfc0  0c 1040ff17 0 0 0
mtc0  0d ffffffff 0 0 0
mfc0  0d 00800300 0 0 0
mtc0  0a ffffffff 0 0 0
mfc0  0a ffffe0ff 0 0 0
mtc0  04 ffffffff 0 0 0
mfc0  04 ff800000 0 0 0
mtc0  06 ffffffff 0 0 0
mfc0  06 00000007 0 0 0
mtc0  00 ffffffff 0 0 0
mfc0  00 00000007 0 0 0
mfc0  09 00000000 0 0 0
mfc0  0f 00000000 0 0 0
mtc0  0c 00400000 0 0 0
mtc0  0d 00000000 0 0 0
mtc0  06 00000000 0 0 0
# tlbwi and the lookup port
mtc0  00 00000002 0 0 0
mtc0  0a 00024005 0 0 0
mtc0  02 0002af3e 0 0 0
mtc0  03 00037be2 0 0 0
tlbwi 0 0 0 0 0
look  00012 1 00abc 00def d
look  00013 0 0 0 0
mtc0  0a 00024006 0 0 0
look  00012 0 0 0 0
mtc0  00 00000003 0 0 0
mtc0  0a 00080006 0 0 0
mtc0  02 00004443 0 0 0
mtc0  03 00008887 0 0 0
tlbwi 0 0 0 0 0
mtc0  00 00000004 0 0 0
mtc0  0a 00082006 0 0 0
mtc0  03 00037be2 0 0 0
tlbwi 0 0 0 0 0
mtc0  0a 00000009 0 0 0
look  00040 1 00111 00222 7
look  00041 0 0 0 0
# tlbp hit and miss, tlbr
mtc0  0a 00024005 0 0 0
tlbp  0 0 0 0 0
mfc0  00 00000002 0 0 0
mtc0  0a 00026005 0 0 0
tlbp  0 0 0 0 0
mfc0  00 80000002 0 0 0
mtc0  02 00000000 0 0 0
mtc0  03 00000000 0 0 0
mtc0  0a 00000000 0 0 0
tlbr  0 0 0 0 0
mfc0  02 0002af1e 0 0 0
mfc0  03 00037bd2 0 0 0
mfc0  0a 00024005 0 0 0
# exception entry and eret
exc   00020 00400100 0 00000000 bfc00380
mfc0  0e 00400100 0 0 0
mfc0  0d 00000020 0 0 0
mfc0  0c 00400002 0 0 0
eret  00400100 0 0 0 0
mfc0  0c 00400000 0 0 0
mtc0  0c 00000000 0 0 0
exc   00101 00400204 1 12345678 80000000
mfc0  0e 00400200 0 0 0
mfc0  0d 80000008 0 0 0
mfc0  08 12345678 0 0 0
mfc0  0a 12344005 0 0 0
mfc0  04 ff891a20 0 0 0
exc   00801 00402000 0 deadbeef 80000180
mfc0  0e 00400200 0 0 0
mfc0  08 00402000 0 0 0
mfc0  0a 00402005 0 0 0
eret  00400200 0 0 0 0
mfc0  0c 00000000 0 0 0
exc   00224 00403000 0 00000abc 80000180
mfc0  0d 00000014 0 0 0
mfc0  08 00000abc 0 0 0
mfc0  0a 00402005 0 0 0
mtc0  1e 00500000 0 0 0
mtc0  0c 00000006 0 0 0
eret  00500000 0 0 0 0
mfc0  0c 00000002 0 0 0
eret  00403000 0 0 0 0
mfc0  0c 00000000 0 0 0
# tlbwr stays above the wired entries
mtc0  06 00000005 0 0 0
mtc0  0a 00200000 0 0 0
tlbwr 0 0 0 0 0
tlbp  0 0 0 0 0
range 00 00000005 00000007 0 0
range 01 00000005 00000007 0 0
mtc0  0a 00202000 0 0 0
tlbwr 0 0 0 0 0
tlbp  0 0 0 0 0
range 00 00000005 00000007 0 0
range 01 00000005 00000007 0 0
mtc0  0a 00204000 0 0 0
tlbwr 0 0 0 0 0
tlbp  0 0 0 0 0
range 00 00000005 00000007 0 0
range 01 00000005 00000007 0 0
mfc0  06 00000005 0 0 0

/* cp0_tlb.f */
design/cp0_pkg.sv
design/cp0_control.sv
design/cp0_regs.sv
design/exc_unit.sv
design/tlb_array.sv
design/cp0_top.sv
bench/cp0_tb.sv

/* design/cp0_control.sv */
module cp0_control (
    input  logic                 clk,
    input  logic                 rst,
    input  cp0_pkg::cp0_cmd_t    cmd,
    input  cp0_pkg::exc_t        exc,
    output cp0_pkg::cp0_action_t action,
    output logic                 jump
);

    logic idle;
    logic exc_req;

    // held idle through reset, so no action leaks out
    always_ff @(posedge clk) begin
        if (rst) begin
            idle <= 1'b1;
        end else begin
            idle <= 1'b0;
        end
    end

    // eret and the refill qualifier are not faults by themselves
    assign exc_req = exc.if_adel | exc.if_tlbl | exc.ex_adel | exc.ex_ades
                   | exc.ex_tlbl | exc.ex_tlbs | exc.ex_tlbm | exc.syscall
                   | exc.brk | exc.ri | exc.ov;

    // fixed priority, everything below the winner is dropped
    always_comb begin
        action = '0;
        if (!idle) begin
            if (exc_req) begin
                action.take_exc = 1'b1;
            end else if (exc.eret) begin
                action.do_eret = 1'b1;
            end else if (cmd.mtc0_en) begin
                action.write_reg = 1'b1;
            end else if (cmd.tlbwi) begin
                action.tlb_write = 1'b1;
            end else if (cmd.tlbwr) begin
                action.tlb_write  = 1'b1;
                action.use_random = 1'b1;
            end else if (cmd.tlbp) begin
                action.tlb_probe = 1'b1;
            end else if (cmd.tlbr) begin
                action.tlb_read = 1'b1;
            end
        end
    end

    assign jump = action.take_exc | action.do_eret;

endmodule

/* design/cp0_pkg.sv */
package cp0_pkg;

    // TLB geometry
    localparam int NR_TLB_ENTRY = 8;
    localparam int TLB_IDX_W    = 3;
    localparam int VPN2_W       = 19;
    localparam int ASID_W       = 8;
    localparam int PFN_W        = 20;

    // register numbers, sel 0 only
    localparam logic [4:0] REG_INDEX    = 5'd0;
    localparam logic [4:0] REG_RANDOM   = 5'd1;
    localparam logic [4:0] REG_ENTRYLO0 = 5'd2;
    localparam logic [4:0] REG_ENTRYLO1 = 5'd3;
    localparam logic [4:0] REG_CONTEXT  = 5'd4;
    localparam logic [4:0] REG_WIRED    = 5'd6;
    localparam logic [4:0] REG_BADVADDR = 5'd8;
    localparam logic [4:0] REG_ENTRYHI  = 5'd10;
    localparam logic [4:0] REG_STATUS   = 5'd12;
    localparam logic [4:0] REG_CAUSE    = 5'd13;
    localparam logic [4:0] REG_EPC      = 5'd14;
    localparam logic [4:0] REG_ERREPC   = 5'd30;

    // Cause.ExcCode values
    localparam logic [4:0] EXC_MOD  = 5'd1;
    localparam logic [4:0] EXC_TLBL = 5'd2;
    localparam logic [4:0] EXC_TLBS = 5'd3;
    localparam logic [4:0] EXC_ADEL = 5'd4;
    localparam logic [4:0] EXC_ADES = 5'd5;
    localparam logic [4:0] EXC_SYS  = 5'd8;
    localparam logic [4:0] EXC_BP   = 5'd9;
    localparam logic [4:0] EXC_RI   = 5'd10;
    localparam logic [4:0] EXC_OV   = 5'd12;

    // exception vectors
    localparam logic [31:0] BEV_BASE       = 32'hbfc0_0200;
    localparam logic [31:0] NORMAL_BASE    = 32'h8000_0000;
    localparam logic [31:0] GENERAL_OFFSET = 32'h0000_0180;
    localparam logic [31:0] REFILL_OFFSET  = 32'h0000_0000;

    typedef struct packed {
        logic                  p;
        logic [30-TLB_IDX_W:0] rsvd;
        logic [TLB_IDX_W-1:0]  index;
    } index_t;

    typedef struct packed {
        logic [5:0]       rsvd;
        logic [PFN_W-1:0] pfn;
        logic [2:0]       c;
        logic             d;
        logic             v;
        logic             g;
    } entrylo_t;

    typedef struct packed {
        logic [VPN2_W-1:0] vpn2;
        logic [4:0]        rsvd;
        logic [ASID_W-1:0] asid;
    } entryhi_t;

    typedef struct packed {
        logic [2:0] rsvd0;
        logic       cu0;
        logic [4:0] rsvd1;
        logic       bev;
        logic [5:0] rsvd2;
        logic [7:0] im;
        logic [2:0] rsvd3;
        logic       um;
        logic       rsvd4;
        logic       erl;
        logic       exl;
        logic       ie;
    } status_t;

    typedef struct packed {
        logic       bd;
        logic [6:0] rsvd0;
        logic       iv;
        logic [6:0] rsvd1;
        logic [7:0] ip;
        logic       rsvd2;
        logic [4:0] exc_code;
        logic [1:0] rsvd3;
    } cause_t;

    typedef struct packed {
        logic [8:0]        pte_base;
        logic [VPN2_W-1:0] bad_vpn2;
        logic [3:0]        rsvd;
    } context_t;

    // one mtc0 word, viewed per target register
    typedef union packed {
        entrylo_t entrylo;
        entryhi_t entryhi;
        status_t  status;
        cause_t   cause;
        context_t ctx;
        index_t   index;
    } cp0_word_u;

    typedef struct packed {
        logic [VPN2_W-1:0] vpn2;
        logic [ASID_W-1:0] asid;
        logic              g;
        logic [PFN_W-1:0]  pfn0;
        logic              c0;
        logic              d0;
        logic              v0;
        logic [PFN_W-1:0]  pfn1;
        logic              c1;
        logic              d1;
        logic              v1;
    } tlb_entry_t;

    typedef struct packed {
        logic       mtc0_en;
        logic       tlbwi;
        logic       tlbwr;
        logic       tlbp;
        logic       tlbr;
        logic [4:0] reg_addr;
    } cp0_cmd_t;

    typedef struct packed {
        logic if_adel;
        logic if_tlbl;
        logic ex_adel;
        logic ex_ades;
        logic ex_tlbl;
        logic ex_tlbs;
        logic ex_tlbm;
        logic syscall;
        logic brk;
        logic ri;
        logic ov;
        logic eret;
        // qualifies if_tlbl/ex_tlbl/ex_tlbs as a refill miss
        logic tlb_refill;
    } exc_t;

    typedef struct packed {
        logic take_exc;
        logic do_eret;
        logic write_reg;
        logic tlb_write;
        logic use_random;
        logic tlb_probe;
        logic tlb_read;
    } cp0_action_t;

endpackage

/* design/cp0_regs.sv */
module cp0_regs (
    input  logic                          clk,
    input  logic                          rst,
    input  cp0_pkg::cp0_action_t          action,
    input  logic [4:0]                    reg_addr,
    input  logic [31:0]                   mtc0_wdata,
    input  cp0_pkg::exc_t                 exc,
    input  logic [31:0]                   exc_pc,
    input  logic                          exc_bd,
    input  logic [31:0]                   mem_va,
    input  logic [4:0]                    exc_code,
    input  logic                          probe_hit,
    input  logic [cp0_pkg::TLB_IDX_W-1:0] probe_index,
    input  cp0_pkg::tlb_entry_t           read_entry,
    output logic [31:0]                   mfc0_rdata,
    output cp0_pkg::status_t              status,
    output logic [31:0]                   epc,
    output logic [31:0]                   errorepc,
    output cp0_pkg::entryhi_t             entryhi,
    output cp0_pkg::entrylo_t             entrylo0,
    output cp0_pkg::entrylo_t             entrylo1,
    output cp0_pkg::index_t               index,
    output logic [cp0_pkg::TLB_IDX_W-1:0] random
);
    import cp0_pkg::*;

    context_t             ctx;
    cause_t               cause;
    logic [TLB_IDX_W-1:0] wired;
    logic [31:0]          badvaddr;
    cp0_word_u            wd;
    logic [31:0]          badva_in;
    logic                 addr_fault;
    logic                 tlb_fault;

    assign wd = mtc0_wdata;

    // IF faults report the fetch pc, data faults the memory address
    assign badva_in   = (exc.if_adel | exc.if_tlbl) ? exc_pc : mem_va;
    assign tlb_fault  = exc.if_tlbl | exc.ex_tlbl | exc.ex_tlbs | exc.ex_tlbm;
    assign addr_fault = tlb_fault | exc.if_adel | exc.ex_adel | exc.ex_ades;

    always_comb begin
        case (reg_addr)
            REG_INDEX:    mfc0_rdata = index;
            REG_RANDOM:   mfc0_rdata = {{(32-TLB_IDX_W){1'b0}}, random};
            REG_ENTRYLO0: mfc0_rdata = entrylo0;
            REG_ENTRYLO1: mfc0_rdata = entrylo1;
            REG_CONTEXT:  mfc0_rdata = ctx;
            REG_WIRED:    mfc0_rdata = {{(32-TLB_IDX_W){1'b0}}, wired};
            REG_BADVADDR: mfc0_rdata = badvaddr;
            REG_ENTRYHI:  mfc0_rdata = entryhi;
            REG_STATUS:   mfc0_rdata = status;
            REG_CAUSE:    mfc0_rdata = cause;
            REG_EPC:      mfc0_rdata = epc;
            REG_ERREPC:   mfc0_rdata = errorepc;
            default:      mfc0_rdata = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            index    <= '0;
            random   <= TLB_IDX_W'(NR_TLB_ENTRY - 1);
            entrylo0 <= '0;
            entrylo1 <= '0;
            ctx      <= '0;
            wired    <= '0;
            badvaddr <= '0;
            entryhi  <= '0;
            status   <= '{default: '0, bev: 1'b1};
            cause    <= '0;
            epc      <= '0;
            errorepc <= '0;
        end else begin
            // free-running countdown, wraps at Wired
            random <= (random == wired) ? TLB_IDX_W'(NR_TLB_ENTRY - 1) : random - 1'b1;
            if (action.take_exc) begin
                // nested fault keeps the first EPC
                if (!status.exl) begin
                    epc      <= exc_bd ? exc_pc - 32'd4 : exc_pc;
                    cause.bd <= exc_bd;
                end
                status.exl     <= 1'b1;
                cause.exc_code <= exc_code;
                if (addr_fault) begin
                    badvaddr <= badva_in;
                end
                if (tlb_fault) begin
                    ctx.bad_vpn2 <= badva_in[31:13];
                    entryhi.vpn2 <= badva_in[31:13];
                end
            end else if (action.do_eret) begin
                if (status.erl) begin
                    status.erl <= 1'b0;
                end else begin
                    status.exl <= 1'b0;
                end
            end else if (action.write_reg) begin
                case (reg_addr)
                    REG_INDEX:    index.index <= wd.index.index;
                    REG_ENTRYLO0: entrylo0 <= '{rsvd: '0, pfn: wd.entrylo.pfn, c: wd.entrylo.c,
                                                d: wd.entrylo.d, v: wd.entrylo.v, g: wd.entrylo.g};
                    REG_ENTRYLO1: entrylo1 <= '{rsvd: '0, pfn: wd.entrylo.pfn, c: wd.entrylo.c,
                                                d: wd.entrylo.d, v: wd.entrylo.v, g: wd.entrylo.g};
                    REG_CONTEXT:  ctx.pte_base <= wd.ctx.pte_base;
                    REG_WIRED: begin
                        wired  <= mtc0_wdata[TLB_IDX_W-1:0];
                        random <= TLB_IDX_W'(NR_TLB_ENTRY - 1);
                    end
                    REG_ENTRYHI: begin
                        entryhi.vpn2 <= wd.entryhi.vpn2;
                        entryhi.asid <= wd.entryhi.asid;
                    end
                    REG_STATUS: begin
                        status.cu0 <= wd.status.cu0;
                        status.bev <= wd.status.bev;
                        status.im  <= wd.status.im;
                        status.um  <= wd.status.um;
                        status.erl <= wd.status.erl;
                        status.exl <= wd.status.exl;
                        status.ie  <= wd.status.ie;
                    end
                    REG_CAUSE: begin
                        // only the software interrupt bits are writable
                        cause.iv      <= wd.cause.iv;
                        cause.ip[1:0] <= wd.cause.ip[1:0];
                    end
                    REG_EPC:      epc <= mtc0_wdata;
                    REG_ERREPC:   errorepc <= mtc0_wdata;
                    default:      ;
                endcase
            end else if (action.tlb_probe) begin
                if (probe_hit) begin
                    index.index <= probe_index;
                    index.p     <= 1'b0;
                end else begin
                    index.p <= 1'b1;
                end
            end else if (action.tlb_read) begin
                // C comes back with the upper bits fixed at 2'b01
                entrylo0 <= '{rsvd: '0, pfn: read_entry.pfn0, c: {2'd1, read_entry.c0},
                              d: read_entry.d0, v: read_entry.v0, g: read_entry.g};
                entrylo1 <= '{rsvd: '0, pfn: read_entry.pfn1, c: {2'd1, read_entry.c1},
                              d: read_entry.d1, v: read_entry.v1, g: read_entry.g};
                entryhi.vpn2 <= read_entry.vpn2;
                entryhi.asid <= read_entry.asid;
            end
        end
    end

endmodule

/* design/cp0_top.sv */
module cp0_top (
    input  logic                       clk,
    input  logic                       rst,
    input  cp0_pkg::cp0_cmd_t          cmd,
    input  logic [31:0]                mtc0_wdata,
    input  cp0_pkg::exc_t              exc,
    input  logic [31:0]                exc_pc,
    input  logic                       exc_bd,
    input  logic [31:0]                mem_va,
    input  logic [cp0_pkg::VPN2_W-1:0] lookup_vpn2,
    output logic [31:0]                mfc0_rdata,
    output logic                       jump,
    output logic [31:0]                jump_pc,
    output logic                       lookup_found,
    output cp0_pkg::tlb_entry_t        lookup_entry
);
    import cp0_pkg::*;

    cp0_action_t          action;
    logic [4:0]           exc_code;
    status_t              status;
    logic [31:0]          epc;
    logic [31:0]          errorepc;
    entryhi_t             entryhi;
    entrylo_t             entrylo0;
    entrylo_t             entrylo1;
    index_t               index;
    logic [TLB_IDX_W-1:0] random;
    logic                 probe_hit;
    logic [TLB_IDX_W-1:0] probe_index;
    tlb_entry_t           read_entry;

    cp0_control cp0_control_inst (
        .clk    (clk),
        .rst    (rst),
        .cmd    (cmd),
        .exc    (exc),
        .action (action),
        .jump   (jump)
    );

    exc_unit exc_unit_inst (
        .exc      (exc),
        .action   (action),
        .status   (status),
        .epc      (epc),
        .errorepc (errorepc),
        .exc_code (exc_code),
        .jump_pc  (jump_pc)
    );

    cp0_regs cp0_regs_inst (
        .clk         (clk),
        .rst         (rst),
        .action      (action),
        .reg_addr    (cmd.reg_addr),
        .mtc0_wdata  (mtc0_wdata),
        .exc         (exc),
        .exc_pc      (exc_pc),
        .exc_bd      (exc_bd),
        .mem_va      (mem_va),
        .exc_code    (exc_code),
        .probe_hit   (probe_hit),
        .probe_index (probe_index),
        .read_entry  (read_entry),
        .mfc0_rdata  (mfc0_rdata),
        .status      (status),
        .epc         (epc),
        .errorepc    (errorepc),
        .entryhi     (entryhi),
        .entrylo0    (entrylo0),
        .entrylo1    (entrylo1),
        .index       (index),
        .random      (random)
    );

    tlb_array tlb_array_inst (
        .clk          (clk),
        .rst          (rst),
        .action       (action),
        .entryhi      (entryhi),
        .entrylo0     (entrylo0),
        .entrylo1     (entrylo1),
        .index        (index),
        .random       (random),
        .lookup_vpn2  (lookup_vpn2),
        .probe_hit    (probe_hit),
        .probe_index  (probe_index),
        .read_entry   (read_entry),
        .lookup_found (lookup_found),
        .lookup_entry (lookup_entry)
    );

endmodule

/* design/exc_unit.sv */
module exc_unit (
    input  cp0_pkg::exc_t        exc,
    input  cp0_pkg::cp0_action_t action,
    input  cp0_pkg::status_t     status,
    input  logic [31:0]          epc,
    input  logic [31:0]          errorepc,
    output logic [4:0]           exc_code,
    output logic [31:0]          jump_pc
);
    import cp0_pkg::*;

    logic [31:0] trap_base;
    logic [31:0] vec_offset;
    logic        refill;

    // highest-priority fault wins the code
    always_comb begin
        if (exc.if_adel | exc.ex_adel) begin
            exc_code = EXC_ADEL;
        end else if (exc.ex_ades) begin
            exc_code = EXC_ADES;
        end else if (exc.if_tlbl | exc.ex_tlbl) begin
            exc_code = EXC_TLBL;
        end else if (exc.ex_tlbs) begin
            exc_code = EXC_TLBS;
        end else if (exc.ex_tlbm) begin
            exc_code = EXC_MOD;
        end else if (exc.syscall) begin
            exc_code = EXC_SYS;
        end else if (exc.brk) begin
            exc_code = EXC_BP;
        end else if (exc.ri) begin
            exc_code = EXC_RI;
        end else begin
            exc_code = EXC_OV;
        end
    end

    assign refill     = exc.tlb_refill & (exc.if_tlbl | exc.ex_tlbl | exc.ex_tlbs);
    assign trap_base  = status.bev ? BEV_BASE : NORMAL_BASE;
    // refill vector only from a clean EXL
    assign vec_offset = (refill && !status.exl) ? REFILL_OFFSET : GENERAL_OFFSET;

    always_comb begin
        if (action.do_eret) begin
            jump_pc = status.erl ? errorepc : epc;
        end else if (action.take_exc) begin
            jump_pc = trap_base + vec_offset;
        end else begin
            jump_pc = '0;
        end
    end

endmodule

/* design/tlb_array.sv */
module tlb_array (
    input  logic                          clk,
    input  logic                          rst,
    input  cp0_pkg::cp0_action_t          action,
    input  cp0_pkg::entryhi_t             entryhi,
    input  cp0_pkg::entrylo_t             entrylo0,
    input  cp0_pkg::entrylo_t             entrylo1,
    input  cp0_pkg::index_t               index,
    input  logic [cp0_pkg::TLB_IDX_W-1:0] random,
    input  logic [cp0_pkg::VPN2_W-1:0]    lookup_vpn2,
    output logic                          probe_hit,
    output logic [cp0_pkg::TLB_IDX_W-1:0] probe_index,
    output cp0_pkg::tlb_entry_t           read_entry,
    output logic                          lookup_found,
    output cp0_pkg::tlb_entry_t           lookup_entry
);
    import cp0_pkg::*;

    tlb_entry_t              entries [NR_TLB_ENTRY];
    tlb_entry_t              wr_entry;
    logic [TLB_IDX_W-1:0]    wr_idx;
    logic [NR_TLB_ENTRY-1:0] probe_match;
    logic [NR_TLB_ENTRY-1:0] lookup_match;
    logic [TLB_IDX_W-1:0]    lookup_idx;

    // global entries ignore the ASID
    function automatic logic entry_match(input tlb_entry_t e, input logic [VPN2_W-1:0] vpn2,
                                         input logic [ASID_W-1:0] asid);
        return (e.g || e.asid == asid) && e.vpn2 == vpn2;
    endfunction

    // at most one entry should match, so OR-ing the indices is enough
    function automatic logic [TLB_IDX_W-1:0] match_idx(input logic [NR_TLB_ENTRY-1:0] m);
        logic [TLB_IDX_W-1:0] idx;
        idx = '0;
        for (int i = 0; i < NR_TLB_ENTRY; i++) begin
            idx |= m[i] ? TLB_IDX_W'(i) : '0;
        end
        return idx;
    endfunction

    always_comb begin
        for (int i = 0; i < NR_TLB_ENTRY; i++) begin
            probe_match[i]  = entry_match(entries[i], entryhi.vpn2, entryhi.asid);
            lookup_match[i] = entry_match(entries[i], lookup_vpn2, entryhi.asid);
        end
    end

    assign probe_hit    = |probe_match;
    assign probe_index  = match_idx(probe_match);
    assign lookup_found = |lookup_match;
    assign lookup_idx   = match_idx(lookup_match);
    assign lookup_entry = entries[lookup_idx];
    assign read_entry   = entries[index.index];

    assign wr_idx = action.use_random ? random : index.index;
    assign wr_entry = '{vpn2: entryhi.vpn2, asid: entryhi.asid,
                        g: entrylo0.g & entrylo1.g,
                        pfn0: entrylo0.pfn, c0: entrylo0.c[0], d0: entrylo0.d, v0: entrylo0.v,
                        pfn1: entrylo1.pfn, c1: entrylo1.c[0], d1: entrylo1.d, v1: entrylo1.v};

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NR_TLB_ENTRY; i++) begin
                entries[i] <= '0;
            end
        end else if (action.tlb_write) begin
            entries[wr_idx] <= wr_entry;
        end
    end

endmodule
